//--- Makefile
# Verilator build and run of the CQ receive testbench

VERILATOR ?= verilator
TOP       ?= cq_rx_tb
FILELIST  ?= list.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -qx "=== PASS ===" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- list.f
source/cq_rx_pkg.sv
source/cq_beat_if.sv
source/cq_header_parser.sv
source/cq_write_packer.sv
source/cq_read_responder.sv
source/rx_throughput_meter.sv
source/cq_rx_engine.sv
verification/cq_rx_props.sv
verification/cq_rx_checker.sv
verification/cq_rx_tb.sv

//--- source/cq_beat_if.sv
// cq beat interface
// accepted, decoded CQ beats from the parser to the write and read paths

`timescale 1ns/1ps

interface cq_beat_if;
   logic                          beat_valid;   // beat accepted this cycle
   logic                          beat_sop;
   logic                          beat_last;
   logic [cq_rx_pkg::DATA_W-1:0]  beat_data;
   cq_rx_pkg::req_kind_e          beat_kind;    // held for the whole packet
   logic [cq_rx_pkg::DW_CNT_W-1:0] beat_dw_cnt; // valid on sop only
   logic [cq_rx_pkg::BE_W-1:0]    beat_be;
   logic                          rd_busy;      // back toward the parser

   modport parser (output beat_valid, beat_sop, beat_last, beat_data, beat_kind,
                   output beat_dw_cnt, beat_be, input rd_busy);
   modport packer (input beat_valid, beat_sop, beat_last, beat_data, beat_kind,
                   input beat_dw_cnt);
   modport responder (input beat_valid, beat_sop, beat_data, beat_kind, beat_be,
                      output rd_busy);
endinterface

//--- source/cq_header_parser.sv
// cq header parser
// tracks packet boundaries on the CQ stream, decodes the start beat and
// owns tready, including the gaps after read headers and write ends

`timescale 1ns/1ps

module cq_header_parser (
   input  logic                         clk,
   input  logic                         rst_n,
   input  logic [cq_rx_pkg::DATA_W-1:0] cq_tdata_i,
   input  logic                         cq_tvalid_i,
   input  logic                         cq_tlast_i,
   input  logic [7:0]                   cq_be_i,
   output logic                         cq_tready_o,
   cq_beat_if.parser                    beat
);

   logic                                in_pkt_q;    // one cycle behind the bus
   logic                                sop;
   logic                                accept;
   logic                                rd_gap_q;    // cycle after a read header
   logic                                wr_gap_q;    // flush slot after write end
   logic [cq_rx_pkg::REQ_TYPE_W-1:0]    req_type;
   logic [cq_rx_pkg::DW_CNT_W-1:0]      dw_cnt;
   cq_rx_pkg::req_kind_e                dec_kind;
   cq_rx_pkg::req_kind_e                kind_q;

   assign sop      = cq_tvalid_i && !in_pkt_q;
   assign accept   = cq_tvalid_i && cq_tready_o;
   assign req_type = cq_tdata_i[cq_rx_pkg::REQ_TYPE_LSB +: cq_rx_pkg::REQ_TYPE_W];
   assign dw_cnt   = cq_tdata_i[cq_rx_pkg::DW_CNT_LSB +: cq_rx_pkg::DW_CNT_W];

   // only 1DW reads get a completion, long reads drop out here
   always_comb begin
      dec_kind = cq_rx_pkg::KIND_NONE;
      if (req_type == cq_rx_pkg::CQ_MEM_WR)
         dec_kind = cq_rx_pkg::KIND_WR;
      else if (req_type == cq_rx_pkg::CQ_MEM_RD && dw_cnt == cq_rx_pkg::DW_CNT_W'(1))
         dec_kind = cq_rx_pkg::KIND_RD;
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         in_pkt_q <= 1'b0;
         kind_q   <= cq_rx_pkg::KIND_NONE;
         rd_gap_q <= 1'b0;
         wr_gap_q <= 1'b0;
      end else begin
         if (accept && cq_tlast_i)
            in_pkt_q <= 1'b0;                      // packet done
         else if (accept && sop)
            in_pkt_q <= 1'b1;
         if (accept && sop)
            kind_q <= dec_kind;                    // hold kind for later beats
         rd_gap_q <= accept && sop && dec_kind == cq_rx_pkg::KIND_RD;
         wr_gap_q <= accept && cq_tlast_i && beat.beat_kind == cq_rx_pkg::KIND_WR;
      end
   end

   assign cq_tready_o = !beat.rd_busy && !rd_gap_q && !wr_gap_q;

   // decoded beat toward packer and responder
   assign beat.beat_valid  = accept;
   assign beat.beat_sop    = sop;
   assign beat.beat_last   = cq_tlast_i;
   assign beat.beat_data   = cq_tdata_i;
   assign beat.beat_kind   = sop ? dec_kind : kind_q;
   assign beat.beat_dw_cnt = dw_cnt;                // header field, sop only
   assign beat.beat_be     = cq_be_i;

endmodule

//--- source/cq_read_responder.sv
// cq read responder
// captures 1DW memory read headers and holds the completion request
// until the transmit side reports done

`timescale 1ns/1ps

module cq_read_responder (
   input  logic                         clk,
   input  logic                         rst_n,
   cq_beat_if.responder                 beat,
   input  logic                         compl_done_i,
   output logic                         req_compl_o,
   output logic [2:0]                   req_tc_o,
   output logic [1:0]                   req_attr_o,
   output logic [15:0]                  req_rid_o,
   output logic [7:0]                   req_tag_o,
   output logic [7:0]                   req_be_o,
   output logic [cq_rx_pkg::ADDR_W-1:0] req_addr_o
);

   cq_rx_pkg::rd_state_e state_q;
   logic                 rd_start;

   assign rd_start = state_q == cq_rx_pkg::RD_IDLE && beat.beat_valid && beat.beat_sop
                     && beat.beat_kind == cq_rx_pkg::KIND_RD;

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         state_q <= cq_rx_pkg::RD_IDLE;
      end else begin
         case (state_q)
            cq_rx_pkg::RD_IDLE: if (rd_start) state_q <= cq_rx_pkg::RD_WAIT;
            cq_rx_pkg::RD_WAIT: if (compl_done_i) state_q <= cq_rx_pkg::RD_IDLE;
            default:            state_q <= cq_rx_pkg::RD_IDLE;
         endcase
      end
   end

   // header fields, stable while the request is pending
   always_ff @(posedge clk) begin
      if (rd_start) begin
         req_tc_o   <= beat.beat_data[cq_rx_pkg::TC_LSB +: cq_rx_pkg::TC_W];
         req_attr_o <= beat.beat_data[cq_rx_pkg::ATTR_LSB +: cq_rx_pkg::ATTR_W];
         req_rid_o  <= beat.beat_data[cq_rx_pkg::RID_LSB +: cq_rx_pkg::RID_W];
         req_tag_o  <= beat.beat_data[cq_rx_pkg::TAG_LSB +: cq_rx_pkg::TAG_W];
         req_be_o   <= beat.beat_be;
         req_addr_o <= beat.beat_data[cq_rx_pkg::ADDR_LSB +: cq_rx_pkg::ADDR_W];
      end
   end

   assign req_compl_o  = state_q == cq_rx_pkg::RD_WAIT;
   assign beat.rd_busy = state_q == cq_rx_pkg::RD_WAIT;  // stalls the stream

endmodule

//--- source/cq_rx_engine.sv
// cq rx engine
// completer-request receive path on a 256-bit stream: header parse,
// 1DW read completion requests, write repacking and a throughput meter

`timescale 1ns/1ps

module cq_rx_engine (
   input  logic                         clk,
   input  logic                         rst_n,
   // CQ stream
   input  logic [cq_rx_pkg::DATA_W-1:0] cq_tdata_i,
   input  logic                         cq_tvalid_i,
   input  logic                         cq_tlast_i,
   input  logic [7:0]                   cq_be_i,
   output logic                         cq_tready_o,
   // completion request to tx side
   input  logic                         compl_done_i,
   output logic                         req_compl_o,
   output logic [2:0]                   req_tc_o,
   output logic [1:0]                   req_attr_o,
   output logic [15:0]                  req_rid_o,
   output logic [7:0]                   req_tag_o,
   output logic [7:0]                   req_be_o,
   output logic [cq_rx_pkg::ADDR_W-1:0] req_addr_o,
   // receive FIFO, no back-pressure
   output logic [cq_rx_pkg::DATA_W-1:0] fifo_wr_data_o,
   output logic                         fifo_wr_en_o,
   output logic                         wr_done_o,
   // throughput
   input  logic                         thr_clear_i,
   output logic [31:0]                  thr_count_o,
   output logic                         thr_valid_o
);

   cq_beat_if beat ();

   cq_header_parser u_parser (
      .clk, .rst_n, .cq_tdata_i, .cq_tvalid_i, .cq_tlast_i, .cq_be_i, .cq_tready_o,
      .beat (beat.parser)
   );

   cq_write_packer u_packer (
      .clk, .rst_n, .beat (beat.packer), .fifo_wr_data_o, .fifo_wr_en_o, .wr_done_o
   );

   cq_read_responder u_responder (
      .clk, .rst_n, .beat (beat.responder), .compl_done_i, .req_compl_o,
      .req_tc_o, .req_attr_o, .req_rid_o, .req_tag_o, .req_be_o, .req_addr_o
   );

   rx_throughput_meter #(.WINDOW (cq_rx_pkg::THR_WINDOW_CYCLES)) u_meter (
      .clk, .rst_n,
      .word_i      (fifo_wr_en_o),         // one word per strobe
      .clear_i     (thr_clear_i),
      .thr_count_o,
      .thr_valid_o
   );

endmodule

//--- source/cq_rx_pkg.sv
// cq rx package
// widths, header field positions, opcodes and FSM states shared by the
// completer-request receive path

package cq_rx_pkg;

   // stream and DW widths
   localparam int DATA_W   = 256;
   localparam int DW_W     = 32;
   localparam int HALF_W   = 128;                  // half beat, four DWs
   localparam int DW_CNT_W = 11;                   // length field
   localparam int ADDR_W   = 11;                   // DW address

   ////////////////////
   // header fields
   ////////////////////
   localparam int ADDR_LSB     = 2;
   localparam int DW_CNT_LSB   = 64;
   localparam int REQ_TYPE_LSB = 75;
   localparam int REQ_TYPE_W   = 4;
   localparam int RID_LSB      = 80;
   localparam int RID_W        = 16;
   localparam int TAG_LSB      = 96;
   localparam int TAG_W        = 8;
   localparam int TC_LSB       = 121;
   localparam int TC_W         = 3;
   localparam int ATTR_LSB     = 124;
   localparam int ATTR_W       = 2;
   localparam int BE_W         = 8;                // first/last DW byte enables
   localparam int PAYLOAD_LSB  = 128;              // DW0 of a header beat

   // short window for simulation, hardware ran 25M cycles (100 ms)
   localparam int THR_WINDOW_CYCLES = 200;

   ////////////////////
   // types
   ////////////////////
   typedef enum logic [3:0] {
      CQ_MEM_RD = 4'b0000,
      CQ_MEM_WR = 4'b0001
   } cq_req_type_e;

   typedef enum logic [1:0] {KIND_NONE, KIND_RD, KIND_WR} req_kind_e;
   typedef enum logic [1:0] {PK_IDLE, PK_PAYLOAD, PK_FLUSH} packer_state_e;
   typedef enum logic {RD_IDLE, RD_WAIT} rd_state_e;

endpackage

//--- source/cq_write_packer.sv
// cq write packer
// repacks write payload DWs into 256-bit FIFO words, DW0 lowest, with a
// 128-bit carry between beats and zero fill of the last word

`timescale 1ns/1ps

module cq_write_packer (
   input  logic                         clk,
   input  logic                         rst_n,
   cq_beat_if.packer                    beat,
   output logic [cq_rx_pkg::DATA_W-1:0] fifo_wr_data_o,
   output logic                         fifo_wr_en_o,
   output logic                         wr_done_o
);

   cq_rx_pkg::packer_state_e            state_q;
   logic [cq_rx_pkg::DW_CNT_W-1:0]      dw_left_q;   // DWs still to arrive
   logic [cq_rx_pkg::HALF_W-1:0]        carry_q;     // upper half of previous beat
   logic [cq_rx_pkg::HALF_W-1:0]        beat_lo;
   logic [cq_rx_pkg::HALF_W-1:0]        beat_hi;
   logic                                wr_start;

   // keep the lowest n DWs of a half beat, zero the rest
   function automatic logic [cq_rx_pkg::HALF_W-1:0] keep_dws(
      input logic [cq_rx_pkg::HALF_W-1:0]   half,
      input logic [cq_rx_pkg::DW_CNT_W-1:0] n
   );
      logic [cq_rx_pkg::HALF_W-1:0] res;
      res = '0;
      for (int i = 0; i < cq_rx_pkg::HALF_W / cq_rx_pkg::DW_W; i++) begin
         if (n > i)
            res[i*cq_rx_pkg::DW_W +: cq_rx_pkg::DW_W] = half[i*cq_rx_pkg::DW_W +: cq_rx_pkg::DW_W];
      end
      return res;
   endfunction

   assign beat_lo  = beat.beat_data[0 +: cq_rx_pkg::HALF_W];
   assign beat_hi  = beat.beat_data[cq_rx_pkg::PAYLOAD_LSB +: cq_rx_pkg::HALF_W];
   assign wr_start = beat.beat_valid && beat.beat_sop && beat.beat_kind == cq_rx_pkg::KIND_WR;

   ////////////////////
   // control FSM
   ////////////////////
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         state_q      <= cq_rx_pkg::PK_IDLE;
         dw_left_q    <= '0;
         fifo_wr_en_o <= 1'b0;
         wr_done_o    <= 1'b0;
      end else begin
         fifo_wr_en_o <= 1'b0;                     // single-cycle strobes
         wr_done_o    <= 1'b0;
         case (state_q)
            cq_rx_pkg::PK_IDLE: if (wr_start) begin
               if (beat.beat_last) begin           // 1..4 DWs, one word
                  fifo_wr_en_o <= 1'b1;
                  wr_done_o    <= 1'b1;
               end else begin
                  dw_left_q <= beat.beat_dw_cnt - cq_rx_pkg::DW_CNT_W'(4);
                  state_q   <= cq_rx_pkg::PK_PAYLOAD;
               end
            end
            cq_rx_pkg::PK_PAYLOAD: if (beat.beat_valid) begin
               fifo_wr_en_o <= 1'b1;               // carry + low half
               if (beat.beat_last) begin
                  if (dw_left_q > cq_rx_pkg::DW_CNT_W'(4)) begin
                     state_q <= cq_rx_pkg::PK_FLUSH;  // leftover in upper half
                  end else begin
                     wr_done_o <= 1'b1;
                     state_q   <= cq_rx_pkg::PK_IDLE;
                  end
               end else begin
                  dw_left_q <= dw_left_q - cq_rx_pkg::DW_CNT_W'(8);
               end
            end
            cq_rx_pkg::PK_FLUSH: begin             // tready held low here
               fifo_wr_en_o <= 1'b1;
               wr_done_o    <= 1'b1;
               state_q      <= cq_rx_pkg::PK_IDLE;
            end
            default: state_q <= cq_rx_pkg::PK_IDLE;
         endcase
      end
   end

   // datapath, words only qualified by fifo_wr_en_o
   always_ff @(posedge clk) begin
      if (state_q == cq_rx_pkg::PK_FLUSH) begin
         fifo_wr_data_o <= {{cq_rx_pkg::HALF_W{1'b0}}, carry_q};
      end else if (beat.beat_valid) begin
         if (state_q == cq_rx_pkg::PK_PAYLOAD) begin
            fifo_wr_data_o <= {keep_dws(beat_lo, dw_left_q), carry_q};
            carry_q        <= keep_dws(beat_hi, dw_left_q - cq_rx_pkg::DW_CNT_W'(4));
         end else begin
            fifo_wr_data_o <= {{cq_rx_pkg::HALF_W{1'b0}}, keep_dws(beat_hi, beat.beat_dw_cnt)};
            carry_q        <= beat_hi;            // DW0..3 of a long write
         end
      end
   end

endmodule

//--- source/rx_throughput_meter.sv
// rx throughput meter
// counts FIFO words in fixed windows and reports each window's count

`timescale 1ns/1ps

module rx_throughput_meter #(
   parameter int WINDOW = cq_rx_pkg::THR_WINDOW_CYCLES
) (
   input  logic        clk,
   input  logic        rst_n,
   input  logic        word_i,
   input  logic        clear_i,
   output logic [31:0] thr_count_o,
   output logic        thr_valid_o
);

   logic [$clog2(WINDOW)-1:0] win_q;     // cycle within window
   logic [31:0]               words_q;   // words so far this window
   logic                      win_end;

   assign win_end = win_q == ($clog2(WINDOW))'(WINDOW - 1);

   always_ff @(posedge clk) begin
      if (!rst_n || clear_i) begin
         win_q       <= '0;
         words_q     <= '0;
         thr_count_o <= '0;
         thr_valid_o <= 1'b0;
      end else begin
         thr_valid_o <= win_end;
         if (win_end) begin
            win_q       <= '0;
            words_q     <= '0;                     // restart window
            thr_count_o <= words_q + 32'(word_i);  // includes this last cycle
         end else begin
            win_q   <= win_q + 1'b1;
            words_q <= words_q + 32'(word_i);
         end
      end
   end

endmodule

//--- verification/cq_rx_checker.sv
// cq rx checker
// reference model of the receive engine, watches the DUT ports on the
// falling edge and compares FIFO words, read requests and window counts

`timescale 1ns/1ps

module cq_rx_checker (
   input  logic                         clk,
   input  logic                         rst_n,
   input  logic [cq_rx_pkg::DATA_W-1:0] cq_tdata_i,
   input  logic                         cq_tvalid_i,
   input  logic                         cq_tlast_i,
   input  logic [7:0]                   cq_be_i,
   input  logic                         cq_tready_o,
   input  logic                         compl_done_i,
   input  logic                         req_compl_o,
   input  logic [2:0]                   req_tc_o,
   input  logic [1:0]                   req_attr_o,
   input  logic [15:0]                  req_rid_o,
   input  logic [7:0]                   req_tag_o,
   input  logic [7:0]                   req_be_o,
   input  logic [cq_rx_pkg::ADDR_W-1:0] req_addr_o,
   input  logic [cq_rx_pkg::DATA_W-1:0] fifo_wr_data_o,
   input  logic                         fifo_wr_en_o,
   input  logic                         wr_done_o,
   input  logic [31:0]                  thr_count_o,
   input  logic                         thr_valid_o,
   output int                           err_cnt_o,
   output int                           pending_o
);

   logic [cq_rx_pkg::DATA_W:0]   exp_words[$];   // {last of packet, word}
   logic [47:0]                  exp_reads[$];   // {tc, attr, rid, tag, be, addr}
   logic [cq_rx_pkg::DATA_W:0]   exp_w;
   logic [47:0]                  exp_r;
   logic [cq_rx_pkg::DATA_W-1:0] word;           // word being gathered
   logic [3:0]                   req_type;
   logic [10:0]                  len;
   logic                         acc;
   logic                         in_pkt;
   logic                         is_wr;
   logic                         compl_q;
   logic                         done_q;
   int                           fill;           // DWs in word
   int                           dw_left;        // payload DWs still owed
   int                           win_words;
   int                           cyc_since;      // cycles since last meter pulse or reset

   task automatic report_error(input string msg);
      err_cnt_o++;
      $display("Error at %0d ns: %s", $time, msg);
   endtask

   // next payload DW in order, eight per word, DW0 lowest
   task automatic add_payload_dw(input logic [31:0] dw);
      if (dw_left > 0) begin
         word[fill*32 +: 32] = dw;
         fill++;
         dw_left--;
         if (fill == 8) begin
            exp_words.push_back({dw_left == 0, word});
            word = '0;
            fill = 0;
         end
      end
   endtask

   assign acc = cq_tvalid_i && cq_tready_o;      // transfers at the next edge

   always @(negedge clk) begin
      if (!rst_n) begin
         exp_words.delete();
         exp_reads.delete();
         word      = '0;
         in_pkt    = 1'b0;
         is_wr     = 1'b0;
         compl_q   = 1'b0;
         done_q    = 1'b0;
         fill      = 0;
         dw_left   = 0;
         win_words = 0;
         cyc_since = -1;                         // first cycle out of reset is cycle 0
         err_cnt_o = 0;
      end else begin
         ////////////////////
         // FIFO words
         ////////////////////
         if (fifo_wr_en_o) begin
            if (exp_words.size() == 0) begin
               report_error($sformatf("unexpected FIFO word %h", fifo_wr_data_o));
            end else begin
               exp_w = exp_words.pop_front();
               if (fifo_wr_data_o !== exp_w[cq_rx_pkg::DATA_W-1:0])
                  report_error($sformatf("FIFO word %h, expected %h", fifo_wr_data_o,
                                         exp_w[cq_rx_pkg::DATA_W-1:0]));
               if (wr_done_o !== exp_w[cq_rx_pkg::DATA_W])
                  report_error($sformatf("wr_done_o %b, expected %b", wr_done_o,
                                         exp_w[cq_rx_pkg::DATA_W]));
            end
         end else if (wr_done_o) begin
            report_error("wr_done_o without a FIFO word");
         end

         // completion request fields and hold
         if (req_compl_o && !compl_q) begin
            if (exp_reads.size() == 0) begin
               report_error("req_compl_o raised with no 1DW read pending");
            end else begin
               exp_r = exp_reads.pop_front();
               if ({req_tc_o, req_attr_o, req_rid_o, req_tag_o, req_be_o, req_addr_o} !== exp_r)
                  report_error($sformatf("read request fields %h, expected %h",
                     {req_tc_o, req_attr_o, req_rid_o, req_tag_o, req_be_o, req_addr_o}, exp_r));
            end
         end
         if (compl_q && !done_q && !req_compl_o)
            report_error("req_compl_o dropped before compl_done_i");
         if (req_compl_o && acc)
            report_error("beat accepted while a completion is pending");

         ////////////////////
         // throughput windows
         ////////////////////
         cyc_since++;
         if (thr_valid_o) begin
            if (thr_count_o !== 32'(win_words))
               report_error($sformatf("thr_count_o %0d, expected %0d", thr_count_o, win_words));
            if (cyc_since != cq_rx_pkg::THR_WINDOW_CYCLES)
               report_error($sformatf("meter pulses %0d cycles apart", cyc_since));
            cyc_since = 0;
            win_words = 0;
         end else if (cyc_since >= cq_rx_pkg::THR_WINDOW_CYCLES) begin
            report_error("no meter pulse at the end of the window");
            cyc_since = 0;
         end
         if (fifo_wr_en_o)
            win_words++;                         // pulse cycle opens the new window

         // input model for a beat that transfers at the next edge
         if (acc) begin
            if (!in_pkt) begin                    // start beat
               req_type = cq_tdata_i[cq_rx_pkg::REQ_TYPE_LSB +: cq_rx_pkg::REQ_TYPE_W];
               len      = cq_tdata_i[cq_rx_pkg::DW_CNT_LSB +: cq_rx_pkg::DW_CNT_W];
               is_wr    = req_type == cq_rx_pkg::CQ_MEM_WR;
               if (req_type == cq_rx_pkg::CQ_MEM_RD && len == 11'd1)
                  exp_reads.push_back({cq_tdata_i[cq_rx_pkg::TC_LSB +: cq_rx_pkg::TC_W],
                                       cq_tdata_i[cq_rx_pkg::ATTR_LSB +: cq_rx_pkg::ATTR_W],
                                       cq_tdata_i[cq_rx_pkg::RID_LSB +: cq_rx_pkg::RID_W],
                                       cq_tdata_i[cq_rx_pkg::TAG_LSB +: cq_rx_pkg::TAG_W],
                                       cq_be_i,
                                       cq_tdata_i[cq_rx_pkg::ADDR_LSB +: cq_rx_pkg::ADDR_W]});
               dw_left = is_wr ? int'(len) : 0;
               fill    = 0;
               word    = '0;
               for (int i = 4; i < 8; i++)
                  add_payload_dw(cq_tdata_i[i*32 +: 32]);
            end else begin
               for (int i = 0; i < 8; i++)
                  add_payload_dw(cq_tdata_i[i*32 +: 32]);
            end
            if (cq_tlast_i && is_wr && fill > 0)
               exp_words.push_back({1'b1, word});  // zero-filled tail
            in_pkt = !cq_tlast_i;
         end
         compl_q = req_compl_o;
         done_q  = compl_done_i;
      end
      pending_o = exp_words.size() + exp_reads.size();
   end

endmodule

//--- verification/cq_rx_props.sv
// cq rx properties
// stream and read handshake assertions, bound into the receive engine

`timescale 1ns/1ps

module cq_rx_props (
   input logic                         clk,
   input logic                         rst_n,
   input logic [cq_rx_pkg::DATA_W-1:0] cq_tdata_i,
   input logic                         cq_tvalid_i,
   input logic                         cq_tlast_i,
   input logic                         cq_tready_o,
   input logic                         req_compl_o,
   input logic                         compl_done_i,
   input logic                         fifo_wr_en_o,
   input logic                         wr_done_o
);

   logic in_pkt_q;
   logic wr_pkt_q;    // packet in flight is a write
   logic acc;
   logic is_wr;

   assign acc   = cq_tvalid_i && cq_tready_o;
   assign is_wr = in_pkt_q ? wr_pkt_q
                : cq_tdata_i[cq_rx_pkg::REQ_TYPE_LSB +: cq_rx_pkg::REQ_TYPE_W]
                  == cq_rx_pkg::CQ_MEM_WR;

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         in_pkt_q <= 1'b0;
         wr_pkt_q <= 1'b0;
      end else if (acc) begin
         in_pkt_q <= !cq_tlast_i;
         wr_pkt_q <= is_wr;
      end
   end

   a_ready_after_reset: assert property (@(posedge clk) $rose(rst_n) |-> cq_tready_o)
      else $error("cq_tready_o low in the first cycle after reset");

   a_compl_hold: assert property (@(posedge clk) disable iff (!rst_n)
      req_compl_o && !compl_done_i |=> req_compl_o)
      else $error("req_compl_o fell before compl_done_i");

   a_flush_gap: assert property (@(posedge clk) disable iff (!rst_n)
      acc && cq_tlast_i && is_wr |=> !cq_tready_o)
      else $error("cq_tready_o high in the flush slot after a write");

   a_done_with_word: assert property (@(posedge clk) disable iff (!rst_n)
      wr_done_o |-> fifo_wr_en_o)
      else $error("wr_done_o without fifo_wr_en_o");

endmodule

//--- verification/cq_rx_tb.sv
// cq rx testbench
// random CQ packets into the receive engine, a completion-done responder,
// a cycle limit and the closing report

`timescale 1ns/1ps

module cq_rx_tb;

   localparam int NUM_PKTS   = 60;
   localparam int SEED       = 1629;
   localparam int WINDOW     = cq_rx_pkg::THR_WINDOW_CYCLES;
   localparam int MAX_CYCLES = NUM_PKTS * 8 + 50 + 2 * WINDOW;

   logic                         clk;
   logic                         rst_n;
   logic [cq_rx_pkg::DATA_W-1:0] cq_tdata_i;
   logic                         cq_tvalid_i;
   logic                         cq_tlast_i;
   logic [7:0]                   cq_be_i;
   logic                         cq_tready_o;
   logic                         compl_done_i;
   logic                         req_compl_o;
   logic [2:0]                   req_tc_o;
   logic [1:0]                   req_attr_o;
   logic [15:0]                  req_rid_o;
   logic [7:0]                   req_tag_o;
   logic [7:0]                   req_be_o;
   logic [cq_rx_pkg::ADDR_W-1:0] req_addr_o;
   logic [cq_rx_pkg::DATA_W-1:0] fifo_wr_data_o;
   logic                         fifo_wr_en_o;
   logic                         wr_done_o;
   logic                         thr_clear_i;
   logic [31:0]                  thr_count_o;
   logic                         thr_valid_o;
   int                           err_cnt;
   int                           pending;   // expected items not yet seen
   int                           cycles;
   logic [31:0]                  next_dw;   // incrementing payload value

   cq_rx_engine uut (.*);

   cq_rx_checker u_checker (.*, .err_cnt_o (err_cnt), .pending_o (pending));

   bind cq_rx_engine cq_rx_props u_props (
      .clk, .rst_n, .cq_tdata_i, .cq_tvalid_i, .cq_tlast_i, .cq_tready_o,
      .req_compl_o, .compl_done_i, .fifo_wr_en_o, .wr_done_o
   );

   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk;                     // 20 ns period
   end

   ////////////////////
   // stimulus helpers
   ////////////////////
   function automatic logic [cq_rx_pkg::DATA_W-1:0] random_beat();
      logic [cq_rx_pkg::DATA_W-1:0] d;
      for (int i = 0; i < 8; i++)
         d[i*32 +: 32] = $urandom;
      return d;
   endfunction

   // tvalid low for n cycles, ends 1 ns after an edge
   task automatic idle_cycles(input int n);
      cq_tvalid_i = 1'b0;
      repeat (n) begin
         @(posedge clk);
         #1;
      end
   endtask

   // hold one beat until it transfers
   task automatic send_beat(input logic [cq_rx_pkg::DATA_W-1:0] data, input logic last);
      logic taken;
      taken       = 1'b0;
      cq_tdata_i  = data;
      cq_tvalid_i = 1'b1;
      cq_tlast_i  = last;
      cq_be_i     = 8'($urandom);
      while (!taken) begin
         @(negedge clk);
         taken = cq_tready_o;                      // tready only moves on edges
         @(posedge clk);
         #1;
      end
      cq_tvalid_i = 1'b0;
      cq_tlast_i  = 1'b0;
   endtask

   task automatic send_packet();
      logic [cq_rx_pkg::DATA_W-1:0] data;
      int                           pick;
      int                           len;
      int                           nbeats;
      int                           sent;
      pick   = $urandom_range(3);
      len    = 1;
      nbeats = 1;
      sent   = 0;
      data   = random_beat();
      case (pick)
         0, 1: begin                               // memory write, 1..40 DWs
            len    = $urandom_range(40, 1);
            nbeats = (len <= 4) ? 1 : 1 + (len + 3) / 8;
            data[cq_rx_pkg::REQ_TYPE_LSB +: cq_rx_pkg::REQ_TYPE_W] = cq_rx_pkg::CQ_MEM_WR;
         end
         2: data[cq_rx_pkg::REQ_TYPE_LSB +: cq_rx_pkg::REQ_TYPE_W] = cq_rx_pkg::CQ_MEM_RD;
         default: begin
            if ($urandom_range(1) == 0) begin     // long read, dropped
               len = $urandom_range(16, 2);
               data[cq_rx_pkg::REQ_TYPE_LSB +: cq_rx_pkg::REQ_TYPE_W] = cq_rx_pkg::CQ_MEM_RD;
            end else begin                        // unknown type
               data[cq_rx_pkg::REQ_TYPE_LSB +: cq_rx_pkg::REQ_TYPE_W] = 4'($urandom_range(15, 2));
               nbeats = $urandom_range(3, 1);
            end
         end
      endcase
      data[cq_rx_pkg::DW_CNT_LSB +: cq_rx_pkg::DW_CNT_W] = 11'(len);
      for (int b = 0; b < nbeats; b++) begin
         if (b > 0) begin
            data = random_beat();
            if ($urandom_range(3) == 0)
               idle_cycles($urandom_range(2, 1));  // stall inside the packet
         end
         if (pick <= 1) begin
            // header beat carries DW0..3 in its upper half
            for (int i = (b == 0) ? 4 : 0; i < 8; i++) begin
               if (sent < len) begin
                  data[i*32 +: 32] = next_dw;
                  next_dw          = next_dw + 1;
                  sent++;
               end
            end
         end
         send_beat(data, b == nbeats - 1);
      end
   endtask

   // tx side stand-in, done after 0..5 cycles
   initial begin
      int delay;
      compl_done_i = 1'b0;
      forever begin
         @(posedge clk);
         #1;
         if (req_compl_o) begin
            delay = $urandom_range(5);
            repeat (delay) begin
               @(posedge clk);
               #1;
            end
            compl_done_i = 1'b1;
            @(posedge clk);
            #1;
            compl_done_i = 1'b0;
         end
      end
   end

   ////////////////////
   // main sequence
   ////////////////////
   initial begin
      void'($urandom(SEED));
      rst_n       = 1'b0;
      cq_tdata_i  = '0;
      cq_tvalid_i = 1'b0;
      cq_tlast_i  = 1'b0;
      cq_be_i     = '0;
      thr_clear_i = 1'b0;
      next_dw     = 32'h0000_0001;
      repeat (4) @(posedge clk);
      #1;
      rst_n = 1'b1;
      for (int p = 0; p < NUM_PKTS; p++) begin
         send_packet();
         if ($urandom_range(2) != 0)
            idle_cycles($urandom_range(2, 1));
      end
      repeat (2 * WINDOW + 5) @(posedge clk);   // at least two meter windows
      @(negedge clk);
      #1;
      $display("checker errors: %0d, expected items still pending: %0d", err_cnt, pending);
      if (err_cnt == 0 && pending == 0) begin
         $display("=== PASS ===");
      end else begin
         if (pending != 0)
            $display("some expected FIFO words or read requests never appeared");
         $display("=== FAIL ===");
      end
      $finish;
   end

   always @(posedge clk) begin
      cycles = cycles + 1;
      if (cycles >= MAX_CYCLES) begin
         $display("timeout: the run did not finish within %0d cycles", MAX_CYCLES);
         $display("=== FAIL ===");
         $finish;
      end
   end

endmodule
